//--- design/fp_pkg.sv
// IEEE-754 single-precision layout for the multiply cluster
// Denormals are not represented separately and are treated as zero by the units
`default_nettype none

package fp_pkg;

  //////////////////////////////////////////////////
  // Field widths and bias
  //////////////////////////////////////////////////

  localparam int EXP_W  = 8;
  localparam int MANT_W = 23;
  localparam int BIAS   = 127;

  // All-ones exponent marks infinity or NaN
  localparam int EXP_MAX = 255;

  // Canonical quiet NaN returned on any invalid operation
  localparam logic [31:0] QNAN = 32'h7FC00000;

  //////////////////////////////////////////////////
  // Packed types
  //////////////////////////////////////////////////

  // Sign, biased exponent, fraction without hidden bit
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exponent;
    logic [MANT_W-1:0] mantissa;
  } float_t;

  // Exception flags reported with each result
  typedef struct packed {
    logic overflow;
    logic underflow;
    logic invalid;
  } fp_flags_t;

endpackage

`default_nettype wire

//--- design/fu_pkg.sv
// Cluster-level constants shared by the units and the arbiter
`default_nettype none

package fu_pkg;

  // Number of peer multiply units on the writeback bus
  localparam int N_UNITS = 2;

  // Unit index carried with each writeback
  typedef logic [$clog2(N_UNITS)-1:0] unit_id_t;

  // Radix-4 iterations for a 26-bit zero-padded mantissa
  localparam int BOOTH_STEPS = 13;

  // Cycles from start edge to req, prepare + Booth + normalize
  localparam int UNIT_LATENCY = BOOTH_STEPS + 2;

endpackage

`default_nettype wire

//--- design/wb_if.sv
// Writeback handshake between one unit and the arbiter
// Result and flags must stay stable while req is high and until gnt is seen
`default_nettype none

interface wb_if ();

  // Unit has a finished result waiting
  logic               req;
  // One-cycle grant, combinational in the arbiter
  logic               gnt;
  fp_pkg::float_t     result;
  fp_pkg::fp_flags_t  flags;

  modport unit_mp (
    output req,
    output result,
    output flags,
    input  gnt
  );

  modport arb_mp (
    input  req,
    input  result,
    input  flags,
    output gnt
  );

endinterface

`default_nettype wire

//--- design/booth_radix4_mul.sv
// Unsigned 24x24 iterative radix-4 Booth multiplier, one step per cycle
// done_o pulses 13 cycles after start_i; product holds until the next start
`default_nettype none

module booth_radix4_mul (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,
  input  logic [23:0] a_i,
  input  logic [23:0] b_i,
  output logic [47:0] product_o,
  output logic        done_o
);

  localparam int CNT_W = $clog2(fu_pkg::BOOTH_STEPS);

  // Accumulator works modulo 2^48, final sum is the exact product
  logic [47:0]      acc_q;
  logic [47:0]      mcand_q;
  // Multiplier with appended b[-1], window sits in bits [2:0]
  logic [26:0]      mplier_q;
  logic [CNT_W-1:0] steps_left_q;
  logic             running_q;
  logic             done_q;

  logic [26:0]      mplier_src;
  logic [47:0]      mcand_src;
  logic [47:0]      pp;
  logic [47:0]      acc_next;

  // First step is taken directly from the inputs on the start cycle
  assign mplier_src = start_i ? {2'b00, b_i, 1'b0} : mplier_q;
  assign mcand_src  = start_i ? {24'b0, a_i} : mcand_q;

  // Recode the 3-bit window into 0, +-1 or +-2 times the multiplicand
  always_comb
  begin
    case (mplier_src[2:0])
      3'b001, 3'b010: pp = mcand_src;
      3'b011:         pp = mcand_src << 1;
      3'b100:         pp = -(mcand_src << 1);
      3'b101, 3'b110: pp = -mcand_src;
      default:        pp = '0;
    endcase
  end

  assign acc_next = (start_i ? 48'b0 : acc_q) + pp;

  // Datapath, advances on start and on every running cycle
  always_ff @(posedge clk_i)
  begin
    if (start_i || running_q)
    begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_src << 2;
      mplier_q <= mplier_src >> 2;
    end
  end

  ////////////////////////////////////////////////////
  // Step counter and done strobe
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      running_q    <= 1'b0;
      done_q       <= 1'b0;
      steps_left_q <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (start_i)
      begin
        running_q    <= 1'b1;
        steps_left_q <= CNT_W'(fu_pkg::BOOTH_STEPS - 1);
      end
      else if (running_q)
      begin
        steps_left_q <= steps_left_q - 1'b1;
        // Last step lands this edge
        if (steps_left_q == CNT_W'(1))
        begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  assign product_o = acc_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

//--- design/fp_mul_unit.sv
// Single-precision multiply unit, truncating, denormals flushed to signed zero
// start_i is ignored unless idle; result is held on wb until granted
`default_nettype none

module fp_mul_unit (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  fp_pkg::float_t op_a_i,
  input  fp_pkg::float_t op_b_i,
  output logic           busy_o,
  wb_if.unit_mp          wb
);

  // Signed exponent with room for overflow and negative values
  localparam int EXT_W = fp_pkg::EXP_W + 2;

  typedef enum logic [2:0] {IDLE, PREPARE, MULTIPLY, NORMALIZE, WAIT_GNT} state_e;

  state_e state_q, state_d;

  fp_pkg::float_t        op_a_q, op_b_q;
  logic                  sign_q;
  logic signed [EXT_W-1:0] exp_q;
  fp_pkg::float_t        result_q, result_d;
  fp_pkg::fp_flags_t     flags_q, flags_d;

  logic [47:0]           product;
  logic                  mul_done;
  logic signed [EXT_W-1:0] exp_norm;
  logic [fp_pkg::MANT_W-1:0] mant_norm;
  logic                  a_nan, b_nan, a_inf, b_inf, a_zd, b_zd;

  ////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (start_i) state_d = PREPARE;
      PREPARE:   state_d = MULTIPLY;
      MULTIPLY:  if (mul_done) state_d = NORMALIZE;
      NORMALIZE: state_d = WAIT_GNT;
      WAIT_GNT:  if (wb.gnt) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  // Operands captured only when idle
  always_ff @(posedge clk_i)
  begin
    if (start_i && (state_q == IDLE))
    begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  // Sign and unnormalized exponent, bias removed once
  always_ff @(posedge clk_i)
  begin
    if (state_q == PREPARE)
    begin
      sign_q <= op_a_q.sign ^ op_b_q.sign;
      exp_q  <= EXT_W'(op_a_q.exponent) + EXT_W'(op_b_q.exponent) - EXT_W'(fp_pkg::BIAS);
    end
  end

  // Mantissas with hidden bit, Booth starts during PREPARE
  booth_radix4_mul u_booth (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (state_q == PREPARE),
    .a_i       ({1'b1, op_a_q.mantissa}),
    .b_i       ({1'b1, op_b_q.mantissa}),
    .product_o (product),
    .done_o    (mul_done)
  );

  ////////////////////////////////////////////////////
  // Normalize and special-case resolution
  ////////////////////////////////////////////////////

  // Product in [1,4), top bit set means one right shift
  assign exp_norm  = exp_q + (product[47] ? EXT_W'(1) : EXT_W'(0));
  assign mant_norm = product[47] ? product[46:24] : product[45:23];

  assign a_nan = (op_a_q.exponent == fp_pkg::EXP_MAX) && (op_a_q.mantissa != '0);
  assign b_nan = (op_b_q.exponent == fp_pkg::EXP_MAX) && (op_b_q.mantissa != '0);
  assign a_inf = (op_a_q.exponent == fp_pkg::EXP_MAX) && (op_a_q.mantissa == '0);
  assign b_inf = (op_b_q.exponent == fp_pkg::EXP_MAX) && (op_b_q.mantissa == '0);
  // Zero and denormal behave the same
  assign a_zd  = (op_a_q.exponent == '0);
  assign b_zd  = (op_b_q.exponent == '0);

  always_comb
  begin
    result_d = '{sign: sign_q, exponent: exp_norm[fp_pkg::EXP_W-1:0], mantissa: mant_norm};
    flags_d  = '0;
    if (a_nan || b_nan)
    begin
      result_d        = fp_pkg::QNAN;
      flags_d.invalid = 1'b1;
    end
    else if ((a_inf || b_inf) && (a_zd || b_zd))
    begin
      result_d        = fp_pkg::QNAN;
      flags_d.invalid = 1'b1;
    end
    else if (a_inf || b_inf)
      result_d = '{sign: sign_q, exponent: '1, mantissa: '0};
    else if (a_zd || b_zd)
      result_d = '{sign: sign_q, exponent: '0, mantissa: '0};
    else if (exp_norm >= EXT_W'(fp_pkg::EXP_MAX))
    begin
      result_d         = '{sign: sign_q, exponent: '1, mantissa: '0};
      flags_d.overflow = 1'b1;
    end
    else if (exp_norm <= EXT_W'(0))
    begin
      result_d          = '{sign: sign_q, exponent: '0, mantissa: '0};
      flags_d.underflow = 1'b1;
    end
  end

  // Held until the arbiter takes it
  always_ff @(posedge clk_i)
  begin
    if (state_q == NORMALIZE)
    begin
      result_q <= result_d;
      flags_q  <= flags_d;
    end
  end

  assign busy_o    = (state_q != IDLE);
  assign wb.req    = (state_q == WAIT_GNT);
  assign wb.result = result_q;
  assign wb.flags  = flags_q;

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
// Round-robin writeback arbiter, unit 0 wins first after reset
// Grant is combinational, the shared bus output is registered one cycle later
`default_nettype none

module wb_arbiter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  wb_if.arb_mp              req_ports [fu_pkg::N_UNITS],
  output logic              wb_valid_o,
  output fu_pkg::unit_id_t  wb_unit_o,
  output fp_pkg::float_t    wb_result_o,
  output fp_pkg::fp_flags_t wb_flags_o
);

  logic [fu_pkg::N_UNITS-1:0] req_vec;
  logic [fu_pkg::N_UNITS-1:0] gnt_vec;
  fp_pkg::float_t             result_arr [fu_pkg::N_UNITS];
  fp_pkg::fp_flags_t          flags_arr  [fu_pkg::N_UNITS];
  fu_pkg::unit_id_t           last_q;
  fu_pkg::unit_id_t           gnt_id;
  logic                       gnt_any;
  int                         idx;

  // Flatten the interface array so it can be indexed at run time
  for (genvar i = 0; i < fu_pkg::N_UNITS; i++)
  begin : g_port
    assign req_vec[i]         = req_ports[i].req;
    assign result_arr[i]      = req_ports[i].result;
    assign flags_arr[i]       = req_ports[i].flags;
    assign req_ports[i].gnt   = gnt_vec[i];
  end

  // Search starts just after the last granted unit
  always_comb
  begin
    gnt_any = 1'b0;
    gnt_id  = '0;
    gnt_vec = '0;
    for (int off = 1; off <= fu_pkg::N_UNITS; off++)
    begin
      idx = (int'(last_q) + off) % fu_pkg::N_UNITS;
      if (!gnt_any && req_vec[idx])
      begin
        gnt_any = 1'b1;
        gnt_id  = fu_pkg::unit_id_t'(idx);
      end
    end
    gnt_vec[gnt_id] = gnt_any;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wb_valid_o <= 1'b0;
      last_q     <= fu_pkg::unit_id_t'(fu_pkg::N_UNITS - 1);
    end
    else
    begin
      wb_valid_o <= gnt_any;
      if (gnt_any)
        last_q <= gnt_id;
    end
  end

  // Payload follows the grant, no reset needed
  always_ff @(posedge clk_i)
  begin
    if (gnt_any)
    begin
      wb_unit_o   <= gnt_id;
      wb_result_o <= result_arr[gnt_id];
      wb_flags_o  <= flags_arr[gnt_id];
    end
  end

endmodule

`default_nettype wire

//--- design/fp_mul_cluster.sv
// Two-unit single-precision multiply cluster with one shared writeback port
// No back-pressure on issue; the source must check busy_o before issuing
`default_nettype none

module fp_mul_cluster (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Issue side
  input  logic                       issue_i,
  input  fu_pkg::unit_id_t           issue_unit_i,
  input  fp_pkg::float_t             op_a_i,
  input  fp_pkg::float_t             op_b_i,

  // Status
  output logic [fu_pkg::N_UNITS-1:0] busy_o,

  // Writeback side
  output logic                       wb_valid_o,
  output fu_pkg::unit_id_t           wb_unit_o,
  output fp_pkg::float_t             wb_result_o,
  output logic                       wb_overflow_o,
  output logic                       wb_underflow_o,
  output logic                       wb_invalid_o
);

  fp_pkg::fp_flags_t wb_flags;

  // One handshake per unit
  wb_if wb_bus [fu_pkg::N_UNITS] ();

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////

  for (genvar i = 0; i < fu_pkg::N_UNITS; i++)
  begin : g_unit
    // Issue strobe routed to the named unit only
    fp_mul_unit u_unit (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .start_i (issue_i && (issue_unit_i == fu_pkg::unit_id_t'(i))),
      .op_a_i  (op_a_i),
      .op_b_i  (op_b_i),
      .busy_o  (busy_o[i]),
      .wb      (wb_bus[i])
    );
  end

  //////////////////////////////////////////////////
  // Shared writeback
  //////////////////////////////////////////////////

  wb_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_ports   (wb_bus),
    .wb_valid_o  (wb_valid_o),
    .wb_unit_o   (wb_unit_o),
    .wb_result_o (wb_result_o),
    .wb_flags_o  (wb_flags)
  );

  // Flag bundle split onto plain ports
  assign wb_overflow_o  = wb_flags.overflow;
  assign wb_underflow_o = wb_flags.underflow;
  assign wb_invalid_o   = wb_flags.invalid;

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
// 10 ns clock, reset held low for the first 4 rising edges
`default_nettype none

module clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES   = 4;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // Released on a rising edge like any other driven input
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_fp_mul_cluster.sv
// Random self-checking testbench for the multiply cluster, fixed seed
// Outputs are sampled on the falling edge; issue only goes to a unit seen idle
`default_nettype none

module tb_fp_mul_cluster;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          N_OPS         = 2000;
  localparam int          CYCLES_PER_OP = 40;
  localparam int          CLK_PERIOD_NS = 10;
  localparam int          WATCHDOG_NS   = N_OPS * CYCLES_PER_OP * CLK_PERIOD_NS;
  // Issue edge to wb_valid_o edge for a lone request
  localparam int          LATENCY       = 16;
  localparam int unsigned SEED          = 57058;

  logic                       clk;
  logic                       rst_n;
  logic                       issue_i;
  fu_pkg::unit_id_t           issue_unit_i;
  fp_pkg::float_t             op_a_i;
  fp_pkg::float_t             op_b_i;
  logic [fu_pkg::N_UNITS-1:0] busy_o;
  logic                       wb_valid_o;
  fu_pkg::unit_id_t           wb_unit_o;
  fp_pkg::float_t             wb_result_o;
  logic                       wb_overflow_o;
  logic                       wb_underflow_o;
  logic                       wb_invalid_o;

  // Expected word is {overflow, underflow, invalid, result}
  logic [34:0]                expect_q [fu_pkg::N_UNITS][$];
  int                         due_cycle [fu_pkg::N_UNITS];
  int                         cycle_q;
  int                         issued_cnt;
  int                         checked_cnt;
  logic                       any_issue;
  logic [fu_pkg::N_UNITS-1:0] busy_seen;
  logic                       pick_go;
  fu_pkg::unit_id_t           pick_unit;
  fu_pkg::unit_id_t           mon_unit;
  logic [34:0]                mon_word;
  logic [31:0]                stim_a;
  logic [31:0]                stim_b;

  clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fp_mul_cluster UUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .issue_i        (issue_i),
    .issue_unit_i   (issue_unit_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .busy_o         (busy_o),
    .wb_valid_o     (wb_valid_o),
    .wb_unit_o      (wb_unit_o),
    .wb_result_o    (wb_result_o),
    .wb_overflow_o  (wb_overflow_o),
    .wb_underflow_o (wb_underflow_o),
    .wb_invalid_o   (wb_invalid_o)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // Operand mix leans on special encodings and extreme exponents
  function automatic logic [31:0] rand_operand();
    logic        s;
    logic [7:0]  e;
    logic [22:0] m;
    s = 1'($urandom);
    m = 23'($urandom);
    case ($urandom % 8)
      0: begin e = 8'd0; m = '0; end
      1: begin e = 8'd0; if (m == '0) m = 23'd1; end
      2: begin e = 8'hFF; m = '0; end
      3: begin e = 8'hFF; if (m == '0) m = 23'd1; end
      4: e = 8'(200 + $urandom % 55);
      5: e = 8'(1 + $urandom % 50);
      default: e = 8'(1 + $urandom % 254);
    endcase
    return {s, e, m};
  endfunction

  // Truncating single-precision product, denormals read as zero
  function automatic logic [34:0] ref_model(input logic [31:0] a, input logic [31:0] b);
    int              ea;
    int              eb;
    int              ex;
    longint unsigned ma;
    longint unsigned mb;
    longint unsigned prod;
    longint unsigned frac;
    logic            sign;
    logic            a_nan;
    logic            b_nan;
    logic            a_inf;
    logic            b_inf;
    logic            a_zero;
    logic            b_zero;
    logic [31:0]     res;
    logic [2:0]      flg;
    ea     = int'(a[30:23]);
    eb     = int'(b[30:23]);
    ma     = longint'(a[22:0]) + 64'h80_0000;
    mb     = longint'(b[22:0]) + 64'h80_0000;
    sign   = a[31] ^ b[31];
    a_nan  = (ea == 255) && (a[22:0] != 0);
    b_nan  = (eb == 255) && (b[22:0] != 0);
    a_inf  = (ea == 255) && (a[22:0] == 0);
    b_inf  = (eb == 255) && (b[22:0] == 0);
    a_zero = (ea == 0);
    b_zero = (eb == 0);
    prod   = ma * mb;
    ex     = ea + eb - 127;
    // Product of two values in [1,2) may need one shift right
    if (prod >= 64'h8000_0000_0000)
    begin
      ex   = ex + 1;
      frac = (prod >> 24) & 64'h7F_FFFF;
    end
    else
      frac = (prod >> 23) & 64'h7F_FFFF;
    flg = 3'b000;
    res = {sign, 8'(ex), 23'(frac)};
    // Canonical quiet NaN for every invalid case
    if (a_nan || b_nan)
    begin
      res = 32'h7FC0_0000;
      flg = 3'b001;
    end
    else if ((a_inf || b_inf) && (a_zero || b_zero))
    begin
      res = 32'h7FC0_0000;
      flg = 3'b001;
    end
    else if (a_inf || b_inf)
      res = {sign, 8'hFF, 23'd0};
    else if (a_zero || b_zero)
      res = {sign, 31'd0};
    else if (ex >= 255)
    begin
      res = {sign, 8'hFF, 23'd0};
      flg = 3'b100;
    end
    else if (ex <= 0)
    begin
      res = {sign, 31'd0};
      flg = 3'b010;
    end
    return {flg, res};
  endfunction

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < fu_pkg::N_UNITS; i++)
    begin
      if (expect_q[i].size() != 0)
        empty = 1'b0;
    end
    return empty;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_q <= cycle_q + 1;
  end

  always @(posedge clk)
  begin
    if (!rst_n || (issued_cnt >= N_OPS))
      issue_i <= 1'b0;
    else
    begin
      pick_go   = (($urandom % 2) == 1);
      pick_unit = fu_pkg::unit_id_t'($urandom % fu_pkg::N_UNITS);
      // Strobe now on the bus is taken at this edge, so skip that unit too
      if (pick_go && !busy_seen[pick_unit] && !(issue_i && (issue_unit_i == pick_unit)))
      begin
        stim_a = rand_operand();
        stim_b = rand_operand();
        expect_q[pick_unit].push_back(ref_model(stim_a, stim_b));
        // DUT start edge is two counts ahead of the count read here
        due_cycle[pick_unit] = cycle_q + 2 + LATENCY;
        any_issue  = 1'b1;
        issued_cnt = issued_cnt + 1;
        issue_i      <= 1'b1;
        issue_unit_i <= pick_unit;
        op_a_i       <= stim_a;
        op_b_i       <= stim_b;
      end
      else
        issue_i <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Monitor and scoreboard
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    busy_seen <= busy_o;
    if (rst_n)
    begin
      if (!any_issue)
        assert ((busy_o == '0) && !wb_valid_o)
        else fail_run("busy_o or wb_valid_o went high before the first issue");
      if (wb_valid_o)
      begin
        mon_unit = wb_unit_o;
        assert (expect_q[mon_unit].size() != 0)
        else fail_run($sformatf("Writeback from unit %0d with no result outstanding",
                                mon_unit));
        mon_word = expect_q[mon_unit].pop_front();
        assert (wb_result_o == mon_word[31:0])
        else fail_run($sformatf("CHECK FAILED wb_result_o: expected %h, got %h",
                                mon_word[31:0], wb_result_o));
        assert ({wb_overflow_o, wb_underflow_o, wb_invalid_o} == mon_word[34:32])
        else fail_run($sformatf({"CHECK FAILED {wb_overflow_o,wb_underflow_o,wb_invalid_o}:",
                                 " expected %h, got %h"},
                                mon_word[34:32],
                                {wb_overflow_o, wb_underflow_o, wb_invalid_o}));
        assert (cycle_q == due_cycle[mon_unit])
        else fail_run($sformatf("Unit %0d wrote back at cycle %0d instead of cycle %0d",
                                mon_unit, cycle_q, due_cycle[mon_unit]));
        // Unit is released by the same edge that launches its writeback
        assert (busy_seen[mon_unit] && !busy_o[mon_unit])
        else fail_run($sformatf("Unit %0d busy_o did not fall with its writeback",
                                mon_unit));
        checked_cnt = checked_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    issue_i      = 1'b0;
    issue_unit_i = '0;
    op_a_i       = '0;
    op_b_i       = '0;
    busy_seen    = '1;
    cycle_q      = 0;
    issued_cnt   = 0;
    checked_cnt  = 0;
    any_issue    = 1'b0;
    wait (checked_cnt == N_OPS);
    // Idle tail catches any extra writeback
    repeat (CYCLES_PER_OP) @(posedge clk);
    if (queues_empty())
    begin
      $display("No errors");
      $finish;
    end
    else
      fail_run("Expected results were never written back");
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_run($sformatf("Timeout with %0d of %0d results checked", checked_cnt, N_OPS));
  end

endmodule

`default_nettype wire

//--- list.f
design/fp_pkg.sv
design/fu_pkg.sv
design/wb_if.sv
design/booth_radix4_mul.sv
design/fp_mul_unit.sv
design/wb_arbiter.sv
design/fp_mul_cluster.sv
verification/clock_gen.sv
verification/tb_fp_mul_cluster.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiply cluster testbench with Verilator and runs it.
# The result is read from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_fp_mul_cluster \
  -f list.f \
  -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -qx "No errors" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
